// ==== filelist.f ====
frame_cfg_pkg.sv
rom_pkg.sv
dip_decode.sv
rom_loader.sv
credit_fifo.sv
rom_store.sv
core_shell_top.sv
tb_clk_gen.sv
core_shell_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= core_shell_tb
RTL_TOP   ?= core_shell_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= sim passed

SOURCES := $(shell cat $(FILELIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== core_shell_tb.sv ====
// Shadow ROM tracks every driven byte; all read addresses must lie in a downloaded region
`timescale 1ns/10ps

module core_shell_tb import frame_cfg_pkg::*, rom_pkg::*;;

    localparam int K_DIP  = 0;
    localparam int K_GRST = 1;
    localparam int K_LOAD = 2;
    localparam int K_READ = 3;
    localparam int K_HOLD = 4;     // Download with reads queued behind it
    localparam int NROWS  = 11;

    typedef struct packed {
        int          kind;
        logic [31:0] status;
        int          len;          // Cycles, bytes or reads
        int          base;         // Byte address, or first read address
        logic [3:0]  level;        // Expected difficulty code
    } row_t;

    logic                clk;
    logic                rst_n;
    logic [STATUS_W-1:0] status;
    logic [IOCTL_AW-1:0] ioctl_addr;
    logic [7:0]          ioctl_data;
    logic                ioctl_wr;
    logic                downloading;
    rom_addr_t           req_addr;
    logic                req_push;
    logic                req_credit;
    logic [31:0]         data_read;
    logic                data_valid;
    logic [3:0]          dip_level;
    logic                dip_pause;
    logic                dip_test;
    logic                dip_flip;
    logic                enable_fm;
    logic                enable_psg;
    logic                en_mixing;
    logic                cheat_invincible;
    logic                game_rst_n;

    row_t        tbl [NROWS];
    logic [15:0] shadow [ROM_WORDS];
    rom_addr_t   exp_q [$];         // Reads in request order
    int          rd_cred;
    int          errors;
    int          checks;
    int          cyc;
    int          limit;
    int          err0;
    integer      seed;

    tb_clk_gen clk_gen_i (
        .clk   ( clk   ),
        .rst_n ( rst_n )
    );

    core_shell_top dut_i (
        .clk              ( clk              ),
        .rst_n            ( rst_n            ),
        .status           ( status           ),
        .ioctl_addr       ( ioctl_addr       ),
        .ioctl_data       ( ioctl_data       ),
        .ioctl_wr         ( ioctl_wr         ),
        .downloading      ( downloading      ),
        .req_addr         ( req_addr         ),
        .req_push         ( req_push         ),
        .req_credit       ( req_credit       ),
        .data_read        ( data_read        ),
        .data_valid       ( data_valid       ),
        .dip_level        ( dip_level        ),
        .dip_pause        ( dip_pause        ),
        .dip_test         ( dip_test         ),
        .dip_flip         ( dip_flip         ),
        .enable_fm        ( enable_fm        ),
        .enable_psg       ( enable_psg       ),
        .en_mixing        ( en_mixing        ),
        .cheat_invincible ( cheat_invincible ),
        .game_rst_n       ( game_rst_n       )
    );

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        assert (act === exp) else begin
            $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("%0t: %s", $time, what);
            errors++;
        end
    endtask

    // One clock; outputs are looked at 1 ns after the edge, inputs change after that
    task automatic tick();
        rom_addr_t a;
        int        na;
        @(posedge clk);
        #1;
        if (downloading || status[ST_RST_REQ])
            check_bit("game_rst_n", 1'b0, game_rst_n);
        if (req_credit)
            rd_cred++;
        check_true(rd_cred <= FIFO_DEPTH, "more read credits returned than the queue holds");
        if (data_valid) begin
            check_true(!downloading, "read response arrived while downloading");
            if (exp_q.size() == 0) begin
                check_true(1'b0, "read response with no request outstanding");
            end else begin
                a  = exp_q.pop_front();
                na = (int'(a) + 1) % ROM_WORDS;     // Upper word wraps to 0
                check_val("data_read", {shadow[na], shadow[a]}, data_read);
            end
        end
    endtask

    task automatic push_req(input rom_addr_t a);
        req_addr = a;
        req_push = 1'b1;
        rd_cred--;
        exp_q.push_back(a);
    endtask

    task automatic wait_release();
        int n;
        n = 0;
        while (game_rst_n !== 1'b1 && n < GAME_RST_HOLD + 2) begin
            tick();
            n++;
        end
        check_true(game_rst_n === 1'b1, "game reset still low too long after its cause cleared");
    endtask

    task automatic drain_reads();
        while (exp_q.size() != 0)
            tick();
        check_val("read credits", FIFO_DEPTH, rd_cred);
    endtask

    task automatic check_dip(input logic [31:0] s, input logic [3:0] lvl);
        check_val("dip_level", 32'(lvl), 32'(dip_level));
        check_bit("dip_pause", ~s[ST_PAUSE], dip_pause);
        check_bit("dip_test", ~s[ST_TEST], dip_test);
        check_bit("dip_flip", s[ST_FLIP], dip_flip);
        check_bit("enable_fm", ~s[ST_FM_OFF], enable_fm);
        check_bit("enable_psg", ~s[ST_PSG_OFF], enable_psg);
        check_bit("en_mixing", ~s[ST_FILTER_OFF], en_mixing);
        check_bit("cheat_invincible", s[ST_INVINCIBLE], cheat_invincible);
    endtask

    // One byte per cycle; nreq reads are queued early and must wait for the end
    task automatic download(input int base, input int len, input int nreq);
        int rnd;
        int ba;
        int pushed;
        int span;
        pushed = 0;
        span = len / 2 - 1;                 // Keeps A+1 inside the new data
        downloading = 1'b1;
        for (int i = 0; i < len; i++) begin
            rnd = $random(seed);
            ba = base + i;
            ioctl_addr = IOCTL_AW'(ba);
            ioctl_data = rnd[7:0];
            ioctl_wr = 1'b1;
            if (ba % 2 == 1)
                shadow[ba / 2][15:8] = rnd[7:0];
            else
                shadow[ba / 2][7:0] = rnd[7:0];
            req_push = 1'b0;
            if (i >= 2 && pushed < nreq && rd_cred > 0) begin
                rnd = $random(seed);
                push_req(rom_addr_t'(base / 2 + $unsigned(rnd) % span));
                pushed++;
            end
            tick();
        end
        ioctl_wr = 1'b0;
        req_push = 1'b0;
        repeat (3) tick();                  // Last word reaches the store
        downloading = 1'b0;
        wait_release();
    endtask

    task automatic issue_reads(input int first, input int n);
        int rnd;
        int sent;
        sent = 0;
        while (sent < n) begin
            req_push = 1'b0;
            if (rd_cred > 0) begin
                rnd = $random(seed);
                push_req((sent == 0) ? rom_addr_t'(first) : rnd[ROM_AW-1:0]);
                sent++;
            end
            tick();
        end
        req_push = 1'b0;
        drain_reads();
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= limit) begin
            $display("Timeout after %0d cycles, the tests did not finish", cyc);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        status      = '0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        downloading = 1'b0;
        req_addr    = '0;
        req_push    = 1'b0;
        seed    = 99;
        rd_cred = FIFO_DEPTH;
        errors  = 0;
        checks  = 0;
        cyc     = 0;
        tbl[0]  = '{K_DIP, 32'h0000_0002, 1, 0, 4'b0111};     // Level 0, pause
        tbl[1]  = '{K_DIP, 32'h0000_0014, 1, 0, 4'b1111};     // Level 1, test
        tbl[2]  = '{K_DIP, 32'h0000_0188, 1, 0, 4'b0011};     // Level 2, PSG and FM off
        tbl[3]  = '{K_DIP, 32'h0000_0e0c, 1, 0, 4'b0000};     // Level 3, filter, cheat, flip
        tbl[4]  = '{K_GRST, 32'h0000_8000, 5, 0, 4'b0000};
        tbl[5]  = '{K_LOAD, 32'h0, 2 * ROM_WORDS, 0, 4'b0000};
        tbl[6]  = '{K_READ, 32'h0, 8, ROM_WORDS - 1, 4'b0000};
        tbl[7]  = '{K_READ, 32'h0, 12, 0, 4'b0000};           // Runs the credits dry
        tbl[8]  = '{K_LOAD, 32'h0, 7, 100, 4'b0000};          // Odd tail at word 53
        tbl[9]  = '{K_READ, 32'h0, 2, 53, 4'b0000};
        tbl[10] = '{K_HOLD, 32'h0, 64, 512, 4'b0000};
        limit = 2000;
        for (int i = 0; i < NROWS; i++)
            limit += 20 * tbl[i].len;

        wait (rst_n === 1'b1);
        check_bit("game_rst_n", 1'b0, game_rst_n);
        wait_release();

        for (int i = 0; i < NROWS; i++) begin
            err0 = errors;
            status = tbl[i].status;
            case (tbl[i].kind)
                K_DIP: begin
                    tick();
                    check_dip(tbl[i].status, tbl[i].level);
                end
                K_GRST: begin
                    repeat (tbl[i].len) tick();
                    status = '0;
                    wait_release();
                end
                K_LOAD:  download(tbl[i].base, tbl[i].len, 0);
                K_READ:  issue_reads(tbl[i].base, tbl[i].len);
                default: begin
                    download(tbl[i].base, tbl[i].len, FIFO_DEPTH);
                    drain_reads();
                end
            endcase
            $display("test %0d kind %0d done, %0d errors", i, tbl[i].kind, errors - err0);
        end

        $display("%0d tests, %0d checks, %0d errors", NROWS, checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== tb_clk_gen.sv ====
// Free-running 100 ns clock; rst_n is low for the first 8 rising edges, then held high
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;            // Same 1 ns offset as the other stimulus
    end

endmodule

// ==== core_shell_top.sv ====
// Requester must take data_valid when it shows; only req_credit throttles the read side
`timescale 1ns/10ps

module core_shell_top import frame_cfg_pkg::*, rom_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [STATUS_W-1:0] status,
    input  logic [IOCTL_AW-1:0] ioctl_addr,
    input  logic [7:0]          ioctl_data,
    input  logic                ioctl_wr,
    input  logic                downloading,
    input  rom_addr_t           req_addr,
    input  logic                req_push,
    output logic                req_credit,
    output logic [31:0]         data_read,
    output logic                data_valid,
    output logic [3:0]          dip_level,
    output logic                dip_pause,
    output logic                dip_test,
    output logic                dip_flip,
    output logic                enable_fm,
    output logic                enable_psg,
    output logic                en_mixing,
    output logic                cheat_invincible,
    output logic                game_rst_n
);

    logic       wq_push;
    prog_word_t wq_data;
    logic       wq_credit;
    prog_word_t wq_head;
    logic       wq_not_empty;
    logic       wq_pop;
    rom_addr_t  rq_head;
    logic       rq_not_empty;
    logic       rq_pop;

    dip_decode u_dip (
        .clk              ( clk              ),
        .rst_n            ( rst_n            ),
        .status           ( status           ),
        .downloading      ( downloading      ),
        .dip_level        ( dip_level        ),
        .dip_pause        ( dip_pause        ),
        .dip_test         ( dip_test         ),
        .dip_flip         ( dip_flip         ),
        .enable_fm        ( enable_fm        ),
        .enable_psg       ( enable_psg       ),
        .en_mixing        ( en_mixing        ),
        .cheat_invincible ( cheat_invincible ),
        .game_rst_n       ( game_rst_n       )
    );

    rom_loader u_loader (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .downloading ( downloading ),
        .wq_push     ( wq_push     ),
        .wq_data     ( wq_data     ),
        .wq_credit   ( wq_credit   )
    );

    // Write queue, download words
    credit_fifo #(.payload_t(prog_word_t)) u_wq (
        .clk       ( clk          ),
        .rst_n     ( rst_n        ),
        .push      ( wq_push      ),
        .push_data ( wq_data      ),
        .pop       ( wq_pop       ),
        .head      ( wq_head      ),
        .not_empty ( wq_not_empty ),
        .credit    ( wq_credit    )
    );

    // Read queue, game requests
    credit_fifo #(.payload_t(rom_addr_t)) u_rq (
        .clk       ( clk          ),
        .rst_n     ( rst_n        ),
        .push      ( req_push     ),
        .push_data ( req_addr     ),
        .pop       ( rq_pop       ),
        .head      ( rq_head      ),
        .not_empty ( rq_not_empty ),
        .credit    ( req_credit   )
    );

    rom_store u_store (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .downloading  ( downloading  ),
        .wq_head      ( wq_head      ),
        .wq_not_empty ( wq_not_empty ),
        .wq_pop       ( wq_pop       ),
        .rq_head      ( rq_head      ),
        .rq_not_empty ( rq_not_empty ),
        .rq_pop       ( rq_pop       ),
        .data_read    ( data_read    ),
        .data_valid   ( data_valid   )
    );

endmodule

// ==== rom_store.sv ====
// Array contents are unknown until written; reads are held off for the whole download
`timescale 1ns/10ps

module rom_store import rom_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        downloading,
    input  prog_word_t  wq_head,
    input  logic        wq_not_empty,
    output logic        wq_pop,
    input  rom_addr_t   rq_head,
    input  logic        rq_not_empty,
    output logic        rq_pop,
    output logic [31:0] data_read,
    output logic        data_valid
);

    localparam int REF_W = $clog2(REFRESH_PERIOD);

    logic [1:0][7:0]  mem [ROM_WORDS];  // Stand-in for the SDRAM
    logic [REF_W-1:0] ref_cnt;
    logic             refresh;
    rom_addr_t        rd_next;
    logic [31:0]      dpipe [READ_LATENCY];
    logic [READ_LATENCY-1:0] vpipe;

    // Free-running refresh slot
    always_ff @(posedge clk) begin
        if (!rst_n)
            ref_cnt <= '0;
        else if (refresh)
            ref_cnt <= '0;
        else
            ref_cnt <= ref_cnt + 1'b1;
    end

    assign refresh = (ref_cnt == REF_W'(REFRESH_PERIOD - 1));

    // Refresh first, then writes, then reads
    assign wq_pop = !refresh && wq_not_empty;
    assign rq_pop = !refresh && !wq_not_empty && rq_not_empty && !downloading;

    assign rd_next = rq_head + 1'b1;   // Wraps at the top word

    always_ff @(posedge clk) begin
        if (wq_pop) begin
            if (!wq_head.mask[0])
                mem[wq_head.addr][0] <= wq_head.data[7:0];
            if (!wq_head.mask[1])
                mem[wq_head.addr][1] <= wq_head.data[15:8];
        end
    end

    // Upper half of the read data holds the next word
    always_ff @(posedge clk) begin
        if (rq_pop)
            dpipe[0] <= {mem[rd_next], mem[rq_head]};
        for (int i = 1; i < READ_LATENCY; i++)
            dpipe[i] <= dpipe[i-1];
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            vpipe <= '0;
        else
            vpipe <= {vpipe[READ_LATENCY-2:0], rq_pop};
    end

    assign data_read  = dpipe[READ_LATENCY-1];
    assign data_valid = vpipe[READ_LATENCY-1];

    a_one_pop: assert property (@(posedge clk) disable iff (!rst_n)
        !(wq_pop && rq_pop))
        else $error("rom_store: write and read popped together");

endmodule

// ==== credit_fifo.sv ====
// Sender must follow the credit rule; a push into a full queue is not absorbed
`timescale 1ns/10ps

module credit_fifo import rom_pkg::*; #(
    parameter type payload_t = rom_addr_t
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     not_empty,
    output logic     credit
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    payload_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        ptr_inc = (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign head      = mem[rd_ptr];    // Show-ahead
    assign not_empty = (count != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            credit <= pop;                  // One credit back per pop
            if (push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (count != CNT_W'(FIFO_DEPTH)))
        else $error("credit_fifo: push while full");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> not_empty)
        else $error("credit_fifo: pop while empty");

endmodule

// ==== rom_loader.sv ====
// Download source cannot stall, so words must never outrun the write-queue credits
`timescale 1ns/10ps

module rom_loader import rom_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [IOCTL_AW-1:0] ioctl_addr,
    input  logic [7:0]          ioctl_data,
    input  logic                ioctl_wr,
    input  logic                downloading,
    output logic                wq_push,
    output prog_word_t          wq_data,
    input  logic                wq_credit
);

    logic [7:0]  even_data;       // Low byte waiting for its partner
    rom_addr_t   even_addr;
    logic        pending;
    logic        dl_q;
    logic        odd_wr;
    logic        even_wr;
    logic        pair_ok;
    logic        flush;
    logic        word_rdy;
    prog_word_t  next_word;
    logic [CRED_W-1:0] cred;

    assign odd_wr  = ioctl_wr && ioctl_addr[0];
    assign even_wr = ioctl_wr && !ioctl_addr[0];
    assign pair_ok = pending && (even_addr == ioctl_addr[IOCTL_AW-1:1]);
    assign flush   = dl_q && !downloading && pending && !ioctl_wr; // Odd-length tail
    assign word_rdy = odd_wr || flush;

    always_comb begin
        if (odd_wr) begin
            next_word.addr = ioctl_addr[IOCTL_AW-1:1];
            next_word.data = {ioctl_data, even_data};
            next_word.mask = {1'b0, !pair_ok};    // Lone odd byte keeps the low byte
        end else begin
            next_word.addr = even_addr;
            next_word.data = {8'h00, even_data};
            next_word.mask = 2'b10;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
            dl_q    <= 1'b0;
            wq_push <= 1'b0;
            cred    <= CRED_W'(FIFO_DEPTH);
        end else begin
            dl_q    <= downloading;
            wq_push <= word_rdy;
            if (even_wr)
                pending <= 1'b1;
            else if (word_rdy)
                pending <= 1'b0;
            // Credit is spent when the word is committed
            cred <= cred + CRED_W'(wq_credit) - CRED_W'(word_rdy);
        end
    end

    // Payload only
    always_ff @(posedge clk) begin
        if (even_wr) begin
            even_data <= ioctl_data;
            even_addr <= ioctl_addr[IOCTL_AW-1:1];
        end
        if (word_rdy)
            wq_data <= next_word;
    end

    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        word_rdy |-> (cred != '0 || wq_credit))
        else $error("rom_loader: download word with no write credit left");

endmodule

// ==== dip_decode.sv ====
// Options settle one cycle after status; game reset needs a cause-free run of GAME_RST_HOLD cycles
`timescale 1ns/10ps

module dip_decode import frame_cfg_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [STATUS_W-1:0] status,
    input  logic                downloading,
    output logic [3:0]          dip_level,
    output logic                dip_pause,
    output logic                dip_test,
    output logic                dip_flip,
    output logic                enable_fm,
    output logic                enable_psg,
    output logic                en_mixing,
    output logic                cheat_invincible,
    output logic                game_rst_n
);

    localparam int HOLD_W = $clog2(GAME_RST_HOLD + 1);

    logic [3:0]        level_map;
    logic              rst_cause;
    logic [HOLD_W-1:0] hold_cnt;

    // Difficulty table
    always_comb begin
        case (status[ST_LEVEL_LO +: 2])
            2'd0:    level_map = LEVEL_NORMAL;
            2'd1:    level_map = LEVEL_EASY;
            2'd2:    level_map = LEVEL_HARD;
            default: level_map = LEVEL_VHARD;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dip_level        <= LEVEL_NORMAL;
            dip_pause        <= 1'b1;          // Board pause is active low
            dip_test         <= 1'b1;
            dip_flip         <= 1'b0;
            enable_fm        <= 1'b1;
            enable_psg       <= 1'b1;
            en_mixing        <= 1'b1;
            cheat_invincible <= 1'b0;
        end else begin
            dip_level        <= level_map;
            dip_pause        <= ~status[ST_PAUSE];
            dip_test         <= ~status[ST_TEST];
            dip_flip         <= status[ST_FLIP];
            enable_fm        <= ~status[ST_FM_OFF];
            enable_psg       <= ~status[ST_PSG_OFF];
            en_mixing        <= ~status[ST_FILTER_OFF];
            cheat_invincible <= status[ST_INVINCIBLE];
        end
    end

    assign rst_cause = !rst_n || downloading || status[ST_RST_REQ];

    // Reload on any cause, release when the count runs out
    always_ff @(posedge clk) begin
        if (rst_cause) begin
            hold_cnt   <= HOLD_W'(GAME_RST_HOLD);
            game_rst_n <= 1'b0;
        end else begin
            if (hold_cnt != '0)
                hold_cnt <= hold_cnt - 1'b1;
            game_rst_n <= (hold_cnt <= HOLD_W'(1));
        end
    end

endmodule

// ==== rom_pkg.sv ====
// ROM sizes assume a power-of-two word count so the read address wraps by overflow
package rom_pkg;

    localparam int ROM_AW         = 10;            // Word address width
    localparam int ROM_WORDS      = 1024;
    localparam int IOCTL_AW       = 11;            // Byte address width of the download
    localparam int FIFO_DEPTH     = 4;
    localparam int CRED_W         = 3;             // Holds 0 to FIFO_DEPTH
    localparam int REFRESH_PERIOD = 64;            // Cycles between refresh slots
    localparam int READ_LATENCY   = 2;             // Pop to data_valid, at least 2

    typedef logic [ROM_AW-1:0] rom_addr_t;

    // One program word for the store
    // A mask bit at 1 leaves that byte untouched
    typedef struct packed {
        rom_addr_t   addr;
        logic [15:0] data;
        logic [1:0]  mask;
    } prog_word_t;

endpackage

// ==== frame_cfg_pkg.sv ====
// Bit map follows the OSD status word of the frame. Only one level table, no per-game overrides
package frame_cfg_pkg;

    // Width of the OSD status word
    localparam int STATUS_W = 32;

    // Option bit positions
    localparam int ST_PAUSE      = 1;
    localparam int ST_LEVEL_LO   = 2;   // Two bits, 2 and 3
    localparam int ST_TEST       = 4;
    localparam int ST_PSG_OFF    = 7;
    localparam int ST_FM_OFF     = 8;
    localparam int ST_FILTER_OFF = 9;
    localparam int ST_INVINCIBLE = 10;
    localparam int ST_FLIP       = 11;
    localparam int ST_RST_REQ    = 15;

    // Difficulty codes as the game board expects them
    // Selected by level field 0, 1, 2 and 3 in that order
    localparam logic [3:0] LEVEL_NORMAL = 4'b0111;
    localparam logic [3:0] LEVEL_EASY   = 4'b1111;
    localparam logic [3:0] LEVEL_HARD   = 4'b0011;
    localparam logic [3:0] LEVEL_VHARD  = 4'b0000;

    // Game reset stays low this many cycles after its last cause
    localparam int GAME_RST_HOLD = 16;

endpackage
